// ==== dout_params.svh ====
`ifndef DOUT_PARAMS_SVH
`define DOUT_PARAMS_SVH

// register space selectors in waddr[15:12]
`define ADDR_MAIN       4'h0
`define ADDR_WAVEFORM   4'h8

// offsets inside the main space, waddr[3:0]
`define REG_DIGIOUT     4'h6    // output set/clear, mask in wdata[11:8]
`define OFF_DOUT_CTRL   4'h8    // per channel hi/lo time, channel in waddr[7:4]

// output channels on the board
`define NUM_CHAN        4

// waveform table geometry
`define TABLE_DEPTH     1024
`define TABLE_ADDR_W    10
`define END_CNT_W       23      // duration field of a table entry

// counter widths
`define PWM_TIME_W      16      // hi_time and lo_time
`define DOUT_CFG_CNT_W  12      // detection counter, wraps after 4096 stable cycles

`endif

// ==== dout_pkg.sv ====
`include "dout_params.svh"

package dout_pkg;

    // one word of the waveform table
    typedef struct packed {
        logic                  valid;    // 0 ends playback
        logic [`END_CNT_W-1:0] end_cnt;  // entry lasts end_cnt+1 cycles
        logic [3:0]            pad;      // unused, written as zero by the host
        logic [3:0]            bits;     // output level per channel
    } dout_entry_t;

    typedef logic [`TABLE_ADDR_W-1:0] table_addr_t;

    // one bit per output channel, bit 0 is channel 1
    typedef logic [`NUM_CHAN-1:0] chan_mask_t;

    // per channel control register
    // a zero time keeps the output at its level
    typedef struct packed {
        logic [`PWM_TIME_W-1:0] hi_time;
        logic [`PWM_TIME_W-1:0] lo_time;
    } hilo_t;

endpackage

// ==== dout_pwm.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

// one output channel
// hi_time = lo_time = 0 gives a plain set/clear bit
// hi_time only gives a one-shot high pulse after a set to 1
// both times nonzero give free running PWM
module dout_pwm (
    input  logic           sysclk,
    input  logic           dout_cfg_reset,
    input  logic           ctrl_en,      // control register write strobe
    input  logic           set_en,       // output set strobe
    input  logic           set_val,      // new output level
    input  dout_pkg::hilo_t wdata,
    output dout_pkg::hilo_t ctrl_rdata,
    output logic           dout
);

    import dout_pkg::*;

    hilo_t                  ctrl_q;      // hi/lo times
    logic [`PWM_TIME_W-1:0] timer_q;     // cycles spent at current level
    logic [`PWM_TIME_W-1:0] level_time;  // time that applies to current level

    assign level_time = dout ? ctrl_q.hi_time : ctrl_q.lo_time;
    assign ctrl_rdata = ctrl_q;

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            ctrl_q  <= '0;
            timer_q <= '0;
            dout    <= 1'b0;
        end else if (set_en) begin
            dout    <= set_val;          // host write wins
            timer_q <= '0;               // level starts a fresh period
        end else if (ctrl_en) begin
            ctrl_q  <= wdata;            // timer keeps its count
        end else if (level_time != '0) begin
            // level lasts level_time+1 cycles, counted 0..level_time
            if (timer_q >= level_time) begin
                dout    <= ~dout;
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + 1'b1;
            end
        end
        // zero time holds level and timer
    end

endmodule

// ==== waveform_ram.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

// waveform table, 1024 x 32
// host writes through the waveform space, reads come out one cycle later
module waveform_ram (
    input  logic                  sysclk,
    input  logic                  wen,
    input  dout_pkg::table_addr_t waddr,
    input  logic [31:0]           wdata,
    input  dout_pkg::table_addr_t raddr,
    output dout_pkg::dout_entry_t rdata
);

    import dout_pkg::*;

    dout_entry_t mem [`TABLE_DEPTH];

    // write port
    always_ff @(posedge sysclk) begin
        if (wen) begin
            mem[waddr] <= dout_entry_t'(wdata);
        end
    end

    // registered read port, free running
    always_ff @(posedge sysclk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== waveform_seq.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

// table playback
// raddr is the address the RAM samples on the coming edge, so the next
// entry is fetched on the same edge that the current one ends
module waveform_seq (
    input  logic                  sysclk,
    input  logic                  dout_cfg_reset,
    input  logic                  start,       // output set write
    input  logic                  start_en,    // wdata[31] of that write
    input  dout_pkg::chan_mask_t  start_mask,  // channels to drive from the table
    input  dout_pkg::dout_entry_t entry,       // RAM output
    output dout_pkg::table_addr_t raddr,
    output dout_pkg::chan_mask_t  play_en,
    output logic                  active
);

    import dout_pkg::*;

    table_addr_t           addr_q;      // address of entry on the RAM output
    logic [`END_CNT_W-1:0] cnt_q;       // cycles spent on current entry
    logic                  playing;
    logic                  last_cycle;  // current entry ends on this edge

    assign playing    = (play_en != '0) && entry.valid;
    assign active     = playing;
    assign last_cycle = playing && (cnt_q == entry.end_cnt);

    // fetch address, restarts from entry 0 on start and when idle
    always_comb begin
        if (start || !playing) begin
            raddr = '0;
        end else if (last_cycle) begin
            raddr = addr_q + 1'b1;       // prefetch, wraps at table end
        end else begin
            raddr = addr_q;
        end
    end

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            play_en <= '0;
            addr_q  <= '0;
            cnt_q   <= '0;
        end else if (start) begin
            play_en <= start_en ? start_mask : '0;  // write with bit 31 low stops playback
            addr_q  <= '0;
            cnt_q   <= '0;
        end else if (playing) begin
            if (last_cycle) begin
                addr_q <= raddr;
                cnt_q  <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else begin
            // invalid entry or empty mask, back to idle
            play_en <= '0;
            addr_q  <= '0;
            cnt_q   <= '0;
        end
    end

endmodule

// ==== dout_cfg_detect.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

// startup check of the output driver hardware
// transceiver boards pull both direction pins low, older MOSFET boards
// leave them floating on the weak pullups so both read high
module dout_cfg_detect (
    input  logic sysclk,
    input  logic dout_cfg_reset,
    input  logic dir12_read,
    input  logic dir34_read,
    output logic dir12_reg,       // direction for channels 1-2
    output logic dir34_reg,       // direction for channels 3-4
    output logic dout_cfg_valid,  // detection finished
    output logic dout_cfg_bidir   // transceivers found
);

    logic [`DOUT_CFG_CNT_W-1:0] cfg_cnt;  // consecutive stable cycles
    logic is_old;                         // both pins high
    logic is_new;                         // both pins low
    logic was_old;
    logic was_new;
    logic stable;                         // same decodable state as last cycle

    assign is_old = dir12_read & dir34_read;
    assign is_new = ~(dir12_read | dir34_read);
    assign stable = (was_old & is_old) | (was_new & is_new);  // mixed never counts

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            cfg_cnt        <= '0;
            was_old        <= 1'b0;
            was_new        <= 1'b0;
            dout_cfg_valid <= 1'b0;
            dout_cfg_bidir <= 1'b0;
            dir12_reg      <= 1'b0;
            dir34_reg      <= 1'b0;
        end else if (!dout_cfg_valid) begin
            was_old <= is_old;
            was_new <= is_new;
            if (stable) begin
                cfg_cnt <= cfg_cnt + 1'b1;
                if (&cfg_cnt) begin                // counter wraps, result is final
                    dout_cfg_valid <= 1'b1;
                    dout_cfg_bidir <= is_new;
                    dir12_reg      <= is_new;      // start driving the transceivers
                    dir34_reg      <= is_new;
                end
            end else begin
                cfg_cnt <= '0;                     // pin change restarts the count
            end
        end
        // once valid everything stays frozen until reset
    end

endmodule

// ==== dout_ctrl.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

module dout_ctrl (
    input  logic        sysclk,
    input  logic        dout_cfg_reset,
    input  logic        reg_wen,
    input  logic        dir12_read,
    input  logic        dir34_read,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic [3:0]  io_extra,
    output logic [31:0] reg_rdata,
    output logic [31:0] table_rdata,   // registered, one cycle behind its address
    output logic [31:0] dout,          // status word
    output logic        dir12_reg,
    output logic        dir34_reg,
    output logic        dout_cfg_valid,
    output logic        dout_cfg_bidir
);

    import dout_pkg::*;

    logic        main_wr;      // write into main register space
    logic        dout_set;     // output set write, also starts the table
    logic        dout_ctrl_wr; // control register write, any channel
    logic        table_wen;
    chan_mask_t  set_en;
    chan_mask_t  ctrl_en;
    chan_mask_t  pwm_out;
    chan_mask_t  chan_out;
    chan_mask_t  play_en;
    hilo_t       ctrl_rd [`NUM_CHAN];
    dout_entry_t entry;
    table_addr_t seq_raddr;
    table_addr_t ram_raddr;
    logic        active;
    logic [3:0]  rd_chan;      // channel field of read address, 1..4
    logic [1:0]  rd_idx;

    // write decode
    assign main_wr      = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN);
    assign dout_set     = main_wr && (reg_waddr[7:4] == 4'd0) && (reg_waddr[3:0] == `REG_DIGIOUT);
    assign dout_ctrl_wr = main_wr && (reg_waddr[3:0] == `OFF_DOUT_CTRL);
    assign table_wen    = reg_wen && (reg_waddr[15:12] == `ADDR_WAVEFORM);
    assign set_en       = dout_set ? reg_wdata[11:8] : '0;  // mask picks channels

    for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
        assign ctrl_en[i] = dout_ctrl_wr && (reg_waddr[7:4] == 4'(i + 1));

        dout_pwm pwm_i (
            .sysclk         (sysclk),
            .dout_cfg_reset (dout_cfg_reset),
            .ctrl_en        (ctrl_en[i]),
            .set_en         (set_en[i]),
            .set_val        (reg_wdata[i]),
            .wdata          (hilo_t'(reg_wdata)),
            .ctrl_rdata     (ctrl_rd[i]),
            .dout           (pwm_out[i])
        );

        // table bit while playing, PWM level otherwise
        assign chan_out[i] = (play_en[i] && active) ? entry.bits[i] : pwm_out[i];
    end

    // sequencer owns the read port while playing and on the start write
    assign ram_raddr = ((play_en != '0) || dout_set) ? seq_raddr : reg_raddr[9:0];

    waveform_ram ram_i (
        .sysclk (sysclk),
        .wen    (table_wen),
        .waddr  (reg_waddr[9:0]),
        .wdata  (reg_wdata),
        .raddr  (ram_raddr),
        .rdata  (entry)
    );

    waveform_seq seq_i (
        .sysclk         (sysclk),
        .dout_cfg_reset (dout_cfg_reset),
        .start          (dout_set),
        .start_en       (reg_wdata[31]),
        .start_mask     (reg_wdata[11:8]),
        .entry          (entry),
        .raddr          (seq_raddr),
        .play_en        (play_en),
        .active         (active)
    );

    dout_cfg_detect cfg_i (
        .sysclk         (sysclk),
        .dout_cfg_reset (dout_cfg_reset),
        .dir12_read     (dir12_read),
        .dir34_read     (dir34_read),
        .dir12_reg      (dir12_reg),
        .dir34_reg      (dir34_reg),
        .dout_cfg_valid (dout_cfg_valid),
        .dout_cfg_bidir (dout_cfg_bidir)
    );

    assign table_rdata = entry;

    // control register read-back, channels 1..4 only
    assign rd_chan   = reg_raddr[7:4];
    assign rd_idx    = rd_chan[1:0] - 2'd1;
    assign reg_rdata = ((reg_raddr[15:12] == `ADDR_MAIN) && (reg_raddr[3:0] == `OFF_DOUT_CTRL)
                        && (rd_chan >= 4'd1) && (rd_chan <= 4'd4)) ? ctrl_rd[rd_idx] : '0;

    // status word
    assign dout = {(play_en != '0),  // [31] any channel on the table
                   active,           // [30] valid entry playing
                   4'd0,
                   seq_raddr,        // [25:16] table address
                   8'd0,
                   io_extra,         // [7:4]
                   chan_out};        // [3:0]

endmodule

// ==== tb_dout_ctrl_asserts.sv ====
`timescale 1ns/1ns

module tb_dout_ctrl_asserts (
    input logic        sysclk,
    input logic        dout_cfg_reset,
    input logic        dout_set,        // output set write, starts the table
    input logic [31:0] dout,
    input logic        dout_cfg_valid,
    input logic        dout_cfg_bidir,
    input logic        dir12_reg
);

    logic started;  // a table start since reset

    always_ff @(posedge sysclk) begin
        if (dout_cfg_reset) begin
            started <= 1'b0;
        end else if (dout_set) begin
            started <= 1'b1;
        end
    end

    valid_holds: assert property (@(posedge sysclk) disable iff (dout_cfg_reset)
        $past(dout_cfg_valid) |-> dout_cfg_valid)
        else $error("dout_cfg_valid fell without reset");

    dir_needs_bidir: assert property (@(posedge sysclk) disable iff (dout_cfg_reset)
        dir12_reg |-> dout_cfg_bidir)
        else $error("dir12_reg high without dout_cfg_bidir");

    no_play_before_start: assert property (@(posedge sysclk) disable iff (dout_cfg_reset)
        !started |-> !dout[31])
        else $error("dout[31] set with no table start");

    zero_bits: assert property (@(posedge sysclk)
        (dout[15:8] == 8'd0) && (dout[29:26] == 4'd0))
        else $error("unused status bits not zero");

endmodule

bind dout_ctrl tb_dout_ctrl_asserts asserts_i (
    .sysclk         (sysclk),
    .dout_cfg_reset (dout_cfg_reset),
    .dout_set       (dout_set),
    .dout           (dout),
    .dout_cfg_valid (dout_cfg_valid),
    .dout_cfg_bidir (dout_cfg_bidir),
    .dir12_reg      (dir12_reg)
);

// ==== tb_dout_ctrl.sv ====
`timescale 1ns/1ns
`include "dout_params.svh"

module tb_dout_ctrl;

    import dout_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int DET_LIMIT    = 8000;                        // cycles per detection run
    localparam int WATCH_CYCLES = 3 * (DET_LIMIT + 20) + 2000; // three runs dominate
    localparam int N_ENT        = 8;                           // valid table entries

    logic        sysclk;
    logic        dout_cfg_reset;
    logic        reg_wen;
    logic        dir12_read;
    logic        dir34_read;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [3:0]  io_extra;
    logic [31:0] reg_rdata;
    logic [31:0] table_rdata;
    logic [31:0] dout;
    logic        dir12_reg;
    logic        dir34_reg;
    logic        dout_cfg_valid;
    logic        dout_cfg_bidir;

    int          cyc = 0;         // rising edges seen
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    logic [15:0] lfsr_q;
    logic        cmp_on;          // per cycle compare of dout
    logic [31:0] exp_d;
    logic [15:0] hi_m [4];        // model of the control registers
    logic [15:0] lo_m [4];
    logic        sv_m [4];        // level written by the last set
    int          t0_m [4];        // edge of the last set
    logic        play_on;
    int          play_t0;
    logic [3:0]  play_mask;
    logic [3:0]  ent_bits [N_ENT];
    logic [22:0] ent_cnt [N_ENT];

    dout_ctrl dout_ctrl_i (.*);

    initial begin
        sysclk = 1'b0;
        forever #CLK_HALF sysclk = ~sysclk;
    end

    always @(posedge sysclk) cyc <= cyc + 1;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // one step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // channel level n edges after a set to v where each nonzero time lasts time+1
    function automatic logic level_at(input logic [15:0] hi, input logic [15:0] lo,
                                      input logic v, input int n);
        logic lvl;
        int   rem;
        int   t;
        lvl = v;
        rem = n;
        t = lvl ? int'(hi) : int'(lo);
        while (t != 0 && rem > t) begin
            rem = rem - (t + 1);
            lvl = ~lvl;
            t = lvl ? int'(hi) : int'(lo);
        end
        return lvl;
    endfunction

    // playback n edges after the start write
    function automatic void table_state(input int n, output logic on, output logic act,
                                        output logic [9:0] addr, output logic [3:0] bits);
        int rem;
        int idx;
        rem = n;
        idx = 0;
        on = 1'b0;
        act = 1'b0;
        addr = '0;
        bits = '0;
        while (idx < N_ENT && rem > int'(ent_cnt[idx])) begin
            rem = rem - (int'(ent_cnt[idx]) + 1);
            idx++;
        end
        if (idx < N_ENT) begin
            on = 1'b1;
            act = 1'b1;
            bits = ent_bits[idx];
            addr = (rem == int'(ent_cnt[idx])) ? 10'(idx + 1) : 10'(idx);  // prefetch
        end else if (rem == 0) begin
            on = 1'b1;                   // invalid word out and the mask clears next edge
        end
    endfunction

    function automatic logic [31:0] status_word(input logic [3:0] chan,
            input logic [3:0] extra, input logic [9:0] addr, input logic act,
            input logic any);
        return {any, act, 4'd0, addr, 8'd0, extra, chan};
    endfunction

    function automatic logic [31:0] model_dout();
        logic [3:0] chan;
        logic       on;
        logic       act;
        logic [9:0] addr;
        logic [3:0] bits;
        on = 1'b0;
        act = 1'b0;
        addr = '0;
        bits = '0;
        if (play_on) begin
            table_state(cyc - play_t0, on, act, addr, bits);
        end
        for (int c = 0; c < 4; c++) begin
            chan[c] = (play_mask[c] && act) ? bits[c]
                      : level_at(hi_m[c], lo_m[c], sv_m[c], cyc - t0_m[c]);
        end
        return status_word(chan, io_extra, addr, act, on && (play_mask != 4'd0));
    endfunction

    // control registers at offset 8 of channels 1..4 and zero elsewhere
    function automatic logic [31:0] read_model(input logic [15:0] a);
        int ch;
        ch = int'(a[7:4]);
        if (a[15:12] == `ADDR_MAIN && a[3:0] == `OFF_DOUT_CTRL && ch >= 1 && ch <= 4) begin
            return {hi_m[ch - 1], lo_m[ch - 1]};
        end
        return '0;
    endfunction

    always @(negedge sysclk) begin
        if (cmp_on) begin
            exp_d = model_dout();
            if (dout !== exp_d) begin
                errors++;
                $display("CHECK FAILED dout expected %h got %h cycle %0d", exp_d, dout, cyc);
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            failed_tests++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        next_cycle();                    // taken on this edge
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        #10;
        data = reg_rdata;
    endtask

    task automatic set_write(input logic [3:0] mask, input logic [3:0] val, input logic play);
        bus_write({`ADDR_MAIN, 8'h00, `REG_DIGIOUT}, {play, 19'd0, mask, 4'd0, val});
        for (int c = 0; c < 4; c++) begin
            if (mask[c]) begin
                sv_m[c] = val[c];
                t0_m[c] = cyc;           // timer restarts with the set
            end
        end
    endtask

    task automatic ctrl_write(input int c, input logic [31:0] v);
        bus_write({`ADDR_MAIN, 4'h0, 4'(c + 1), `OFF_DOUT_CTRL}, v);
        hi_m[c] = v[31:16];
        lo_m[c] = v[15:0];
    endtask

    task automatic apply_reset();
        cmp_on = 1'b0;
        play_on = 1'b0;
        play_mask = '0;
        dout_cfg_reset = 1'b1;
        repeat (10) next_cycle();
        dout_cfg_reset = 1'b0;
        for (int c = 0; c < 4; c++) begin
            hi_m[c] = '0;
            lo_m[c] = '0;
            sv_m[c] = 1'b0;
            t0_m[c] = cyc;
        end
    endtask

    // counts edges from reset release until valid with an optional one cycle glitch
    task automatic wait_valid(input int glitch_at, output int n);
        n = 0;
        while (!dout_cfg_valid && n < DET_LIMIT) begin
            next_cycle();
            n++;
            if (glitch_at > 0 && (n == glitch_at || n == glitch_at + 1)) begin
                dir34_read = ~dir34_read;  // one cycle of mixed pins
            end
        end
        if (!dout_cfg_valid) begin
            errors++;
            $display("hardware detection did not finish within %0d cycles", DET_LIMIT);
        end
    endtask

    task automatic detect_hw();
        int e0;
        int n;
        e0 = errors;
        dir12_read = 1'b0;
        dir34_read = 1'b0;
        apply_reset();
        check_val("cfg outputs", 32'h0,
                  {28'd0, dir12_reg, dir34_reg, dout_cfg_valid, dout_cfg_bidir});
        check_val("dout", status_word(4'd0, io_extra, 10'd0, 1'b0, 1'b0), dout);
        wait_valid(0, n);
        if (n < 4096 || n > 4100) begin
            errors++;
            $display("CHECK FAILED valid latency expected 1000..1004 got %h", n);
        end
        check_val("cfg outputs", 32'hF,
                  {28'd0, dir12_reg, dir34_reg, dout_cfg_valid, dout_cfg_bidir});
        dir12_read = 1'b1;               // old drivers
        dir34_read = 1'b1;
        apply_reset();
        wait_valid(0, n);
        check_val("cfg outputs", 32'h2,
                  {28'd0, dir12_reg, dir34_reg, dout_cfg_valid, dout_cfg_bidir});
        dir12_read = 1'b0;
        dir34_read = 1'b0;
        apply_reset();
        wait_valid(1000, n);
        if (n < 5096 || n > 5110) begin
            errors++;
            $display("CHECK FAILED glitch latency expected 13e8..13f6 got %h", n);
        end
        check_val("cfg outputs", 32'hF,
                  {28'd0, dir12_reg, dir34_reg, dout_cfg_valid, dout_cfg_bidir});
        report_test("detection", e0);
    endtask

    task automatic set_and_clear();
        int         e0;
        logic [3:0] m;
        logic [3:0] v;
        logic [3:0] exp_bits;
        e0 = errors;
        cmp_on = 1'b1;
        repeat (12) begin
            m = 4'(rand_bits(4));
            v = 4'(rand_bits(4));
            exp_bits = ({sv_m[3], sv_m[2], sv_m[1], sv_m[0]} & ~m) | (v & m);
            set_write(m, v, 1'b0);
            check_val("dout[3:0]", {28'd0, exp_bits}, {28'd0, dout[3:0]});
        end
        report_test("set/clear", e0);
    endtask

    task automatic pulse_and_pwm();
        int          e0;
        int          c;
        logic [15:0] hi;
        logic [15:0] lo;
        e0 = errors;
        c = int'(rand_bits(2));
        hi = 16'(rand_bits(3)) + 16'd1;
        cmp_on = 1'b0;
        ctrl_write(c, {hi, 16'd0});     // one-shot with low time zero
        set_write(4'(1 << c), 4'hF, 1'b0);
        cmp_on = 1'b1;
        repeat (int'(hi) + 8) next_cycle();
        check_val("one-shot end", 32'h0, {31'd0, dout[c]});
        c = (c + 1) % 4;
        hi = 16'(rand_bits(3)) + 16'd1;
        lo = 16'(rand_bits(3)) + 16'd1;
        cmp_on = 1'b0;
        ctrl_write(c, {hi, lo});
        set_write(4'(1 << c), 4'(rand_bits(4)), 1'b0);
        cmp_on = 1'b1;
        repeat (3 * (int'(hi) + int'(lo) + 2)) next_cycle();
        report_test("one-shot/pwm", e0);
    endtask

    task automatic readback_regs();
        int          e0;
        logic [31:0] v [4];
        logic [31:0] rd;
        logic [15:0] others [6];
        e0 = errors;
        cmp_on = 1'b0;                   // random times move the timers
        for (int c = 0; c < 4; c++) begin
            v[c] = rand_bits(32);
            ctrl_write(c, v[c]);
        end
        for (int c = 0; c < 4; c++) begin
            bus_read({`ADDR_MAIN, 4'h0, 4'(c + 1), `OFF_DOUT_CTRL}, rd);
            check_val("reg_rdata", v[c], rd);
        end
        others = '{16'h0000, 16'h0016, 16'h0008, 16'h0058, 16'h8018, 16'h001A};
        foreach (others[i]) begin
            bus_read(others[i], rd);
            check_val("reg_rdata", read_model(others[i]), rd);
        end
        next_cycle();
        set_write(4'hF, 4'(rand_bits(4)), 1'b0);  // all timers from a known edge
        cmp_on = 1'b1;
        repeat (5) next_cycle();
        report_test("read-back", e0);
    endtask

    task automatic play_table();
        int          e0;
        int          total;
        logic [3:0]  m;
        logic [31:0] exp_w;
        e0 = errors;
        total = 0;
        io_extra = 4'(rand_bits(4));
        for (int i = 0; i < N_ENT; i++) begin
            ent_bits[i] = 4'(rand_bits(4));
            ent_cnt[i] = 23'(rand_bits(2));
            total += int'(ent_cnt[i]) + 1;
            bus_write({`ADDR_WAVEFORM, 2'b00, 10'(i)}, {1'b1, ent_cnt[i], 4'd0, ent_bits[i]});
        end
        bus_write({`ADDR_WAVEFORM, 2'b00, 10'(N_ENT)}, 32'h0);  // end of table
        // host read of the table, RAM output one edge after the address
        for (int i = 0; i <= N_ENT; i++) begin
            reg_raddr = {`ADDR_WAVEFORM, 2'b00, 10'(i)};
            if (i < N_ENT) begin
                exp_w = {1'b1, ent_cnt[i], 4'd0, ent_bits[i]};
            end else begin
                exp_w = 32'h0;
            end
            next_cycle();
            check_val("table_rdata", exp_w, table_rdata);
        end
        m = 4'(rand_bits(4));
        if (m == 4'd0) begin
            m = 4'h5;
        end
        set_write(m, 4'(rand_bits(4)), 1'b1);
        play_on = 1'b1;
        play_t0 = cyc;
        play_mask = m;
        for (int k = 0; k < total + 6; k++) begin
            if (k == total / 2) begin
                io_extra = 4'(rand_bits(4));
            end
            next_cycle();
        end
        check_val("dout[31:16]", 32'h0, {16'd0, dout[31:16]});
        report_test("table playback", e0);
    endtask

    initial begin
        dout_cfg_reset = 1'b1;
        reg_wen = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        io_extra = 4'h9;
        dir12_read = 1'b0;
        dir34_read = 1'b0;
        lfsr_q = 16'd61;
        cmp_on = 1'b0;
        detect_hw();
        set_and_clear();
        pulse_and_pwm();
        readback_regs();
        play_table();
        $display("tests %0d, failed %0d, check errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired, the tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
dout_pkg.sv
dout_pwm.sv
waveform_ram.sv
waveform_seq.sv
dout_cfg_detect.sv
dout_ctrl.sv
tb_dout_ctrl_asserts.sv
tb_dout_ctrl.sv

// ==== run.sh ====
#!/bin/bash
# build and run the dout_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dout_ctrl \
    -o sim_dout_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_dout_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
echo "simulation reported failure"
exit 1
